/* project.f */
rtl/ex_pkg.sv
rtl/ex_bus_if.sv
rtl/ex_alu_branch.sv
rtl/ex_stage_reg.sv
rtl/ex_mem_format.sv
rtl/ex_top.sv
testbench/tb_clkgen.sv
testbench/ex_top_assert.sv
testbench/tb_ex_top.sv

/* rtl/ex_alu_branch.sv */
// combinational decode and execute; op1/op2 come prepared from decode, unknown opcodes do nothing
`timescale 1ns/1ps
module ex_alu_branch import ex_pkg::*; (
    input  logic      valid_i,
    input  word_t     inst_i,
    input  addr_t     instaddr_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    input  word_t     op1_i,
    input  word_t     op2_i,
    input  logic      regs_wen_i,
    input  reg_addr_t rd_addr_i,
    ex_bus_if.src     exec_bus
);

    opcode_e              opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    word_t                i_imm;
    word_t                b_imm;
    word_t                j_imm;
    word_t                sum;
    word_t                diff;
    logic                 eq;
    logic                 lt_s;
    logic                 lt_u;
    logic [SHAMT_W-1:0]   shamt;
    word_t                srl_res;
    alu_op_e              alu_op;
    word_t                alu_res;
    logic                 br_taken;
    store_size_e          st_size;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign i_imm = {{20{inst_i[31]}}, inst_i[31:20]};
    assign b_imm = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign j_imm = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // --------------------------------------------------
    // shared datapath
    // --------------------------------------------------
    assign sum     = op1_i + op2_i;   // alu add, link, lui/auipc, mem address
    assign diff    = op1_i - op2_i;
    assign eq      = (op1_i == op2_i);
    assign lt_s    = $signed(op1_i) < $signed(op2_i);
    assign lt_u    = op1_i < op2_i;
    assign shamt   = op2_i[SHAMT_W-1:0];
    assign srl_res = op1_i >> shamt;

    always_comb begin
        case (funct3)
            F3_ADD:  alu_op = (opcode == OP_REG && funct7 == FUNCT7_ALT) ? SUB : ADD;
            F3_SLL:  alu_op = SLL;
            F3_SLT:  alu_op = SLT;
            F3_SLTU: alu_op = SLTU;
            F3_XOR:  alu_op = XOR;
            F3_SR:   alu_op = (funct7 == FUNCT7_ALT) ? SRA : SRL;
            F3_OR:   alu_op = OR;
            default: alu_op = AND;    // F3_AND
        endcase
    end

    always_comb begin
        case (alu_op)
            ADD:     alu_res = sum;
            SUB:     alu_res = diff;
            AND:     alu_res = op1_i & op2_i;
            OR:      alu_res = op1_i | op2_i;
            XOR:     alu_res = op1_i ^ op2_i;
            SLT:     alu_res = word_t'(lt_s);
            SLTU:    alu_res = word_t'(lt_u);
            SLL:     alu_res = op1_i << shamt;
            SRL:     alu_res = srl_res;
            // sign fill over the bits the logical shift cleared
            SRA:     alu_res = srl_res | ({XLEN{op1_i[XLEN-1]}} & ~({XLEN{1'b1}} >> shamt));
            default: alu_res = '0;
        endcase
    end

    always_comb begin
        case (funct3)
            F3_BEQ:  br_taken = eq;
            F3_BNE:  br_taken = !eq;
            F3_BLT:  br_taken = lt_s;
            F3_BGE:  br_taken = !lt_s;
            F3_BLTU: br_taken = lt_u;
            F3_BGEU: br_taken = !lt_u;
            default: br_taken = 1'b0;  // reserved encodings
        endcase
    end

    always_comb begin
        case (funct3)
            F3_SB:   st_size = SZ_BYTE;
            F3_SH:   st_size = SZ_HALF;
            F3_SW:   st_size = SZ_WORD;
            default: st_size = SZ_NONE;
        endcase
    end

    // --------------------------------------------------
    // per-opcode result, memory and jump fields
    // --------------------------------------------------
    always_comb begin
        exec_bus.valid      = valid_i;
        exec_bus.rd         = rd_addr_i;
        exec_bus.wen        = regs_wen_i;
        exec_bus.result     = '0;
        exec_bus.mem_access = 1'b0;
        exec_bus.mem_write  = 1'b0;
        exec_bus.mem_addr   = '0;
        exec_bus.store_data = '0;
        exec_bus.store_size = SZ_NONE;
        exec_bus.jump_en    = 1'b0;
        exec_bus.jump_base  = JUMP_NONE_BASE;
        exec_bus.jump_ofst  = '0;
        case (opcode)
            OP_IMM, OP_REG: exec_bus.result = alu_res;
            OP_LUI, OP_AUIPC: exec_bus.result = sum;
            OP_JAL: begin
                exec_bus.result    = sum;        // pc + 4
                exec_bus.jump_en   = 1'b1;
                exec_bus.jump_base = instaddr_i;
                exec_bus.jump_ofst = j_imm;
            end
            OP_JALR: begin
                exec_bus.result    = sum;
                exec_bus.jump_en   = 1'b1;
                exec_bus.jump_base = rs1_data_i;
                exec_bus.jump_ofst = i_imm;
            end
            OP_BRANCH: begin
                exec_bus.wen       = 1'b0;
                exec_bus.jump_en   = br_taken;
                exec_bus.jump_base = instaddr_i;
                exec_bus.jump_ofst = b_imm;
            end
            OP_LOAD: begin
                exec_bus.mem_access = 1'b1;
                exec_bus.mem_addr   = sum;
            end
            OP_STORE: begin
                exec_bus.wen        = 1'b0;
                exec_bus.mem_access = 1'b1;
                exec_bus.mem_write  = 1'b1;
                exec_bus.mem_addr   = sum;
                exec_bus.store_data = rs2_data_i;
                exec_bus.store_size = st_size;
            end
            default: ;                       // treated as none
        endcase
    end

endmodule

/* rtl/ex_bus_if.sv */
// one executed instruction between pipeline steps; valid is a plain level, no handshake
`timescale 1ns/1ps
interface ex_bus_if import ex_pkg::*; ();

    logic        valid;
    logic        wen;
    reg_addr_t   rd;
    word_t       result;
    logic        mem_access;   // load or store
    logic        mem_write;
    addr_t       mem_addr;
    word_t       store_data;   // rs2, lanes not yet steered
    store_size_e store_size;
    logic        jump_en;
    addr_t       jump_base;
    addr_t       jump_ofst;

    modport src (
        output valid, wen, rd, result, mem_access, mem_write, mem_addr,
               store_data, store_size, jump_en, jump_base, jump_ofst
    );

    modport dst (
        input  valid, wen, rd, result, mem_access, mem_write, mem_addr,
               store_data, store_size, jump_en, jump_base, jump_ofst
    );

endinterface

/* rtl/ex_mem_format.sv */
// output register stage; stores assume a little-endian word memory with byte write enables
`timescale 1ns/1ps
module ex_mem_format import ex_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    ex_bus_if.dst     held_bus,
    output logic      valid_o,
    output logic      regs_wen_o,
    output reg_addr_t rd_addr_o,
    output word_t     rd_data_o,
    output logic      jump_en_o,
    output addr_t     jump_addr_o,
    output logic      mem_cs_o,
    output logic      mem_we_o,
    output wem_t      mem_wem_o,
    output word_t     mem_din_o,
    output addr_t     mem_addr_o
);

    logic  v;
    logic  do_write;
    logic  do_jump;
    word_t din_nxt;
    wem_t  wem_nxt;

    assign v        = held_bus.valid;
    assign do_write = v & held_bus.mem_access & held_bus.mem_write;
    assign do_jump  = v & held_bus.jump_en;

    // --------------------------------------------------
    // byte lane steering
    // --------------------------------------------------
    always_comb begin
        case (held_bus.store_size)
            SZ_BYTE: begin
                din_nxt = word_t'(held_bus.store_data[7:0]) << {held_bus.mem_addr[1:0], 3'b000};
                wem_nxt = wem_t'(1) << held_bus.mem_addr[1:0];   // one-hot lane
            end
            SZ_HALF: begin
                if (held_bus.mem_addr[1]) begin
                    din_nxt = {held_bus.store_data[15:0], 16'h0000};
                    wem_nxt = 4'b1100;
                end else begin
                    din_nxt = {16'h0000, held_bus.store_data[15:0]};
                    wem_nxt = 4'b0011;
                end
            end
            SZ_WORD: begin
                din_nxt = held_bus.store_data;
                wem_nxt = 4'b1111;
            end
            default: begin
                din_nxt = '0;
                wem_nxt = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_o     <= 1'b0;
            regs_wen_o  <= 1'b0;
            rd_addr_o   <= '0;
            rd_data_o   <= '0;
            jump_en_o   <= 1'b0;
            jump_addr_o <= JUMP_NONE_BASE;
            mem_cs_o    <= 1'b0;
            mem_we_o    <= 1'b0;
            mem_wem_o   <= '0;
            mem_din_o   <= '0;
            mem_addr_o  <= '0;
        end else begin
            valid_o     <= v;
            regs_wen_o  <= v & held_bus.wen;
            rd_addr_o   <= v ? held_bus.rd : '0;
            rd_data_o   <= v ? held_bus.result : '0;
            jump_en_o   <= do_jump;
            jump_addr_o <= do_jump ? held_bus.jump_base + held_bus.jump_ofst : JUMP_NONE_BASE;
            mem_cs_o    <= v & held_bus.mem_access;
            mem_we_o    <= do_write;
            mem_wem_o   <= do_write ? wem_nxt : '0;
            mem_din_o   <= do_write ? din_nxt : '0;
            mem_addr_o  <= (v & held_bus.mem_access) ? held_bus.mem_addr : '0;
        end
    end

endmodule

/* rtl/ex_pkg.sv */
// RV32I execute-stage types and constants; no CSR or M extension, reset address is zero
package ex_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int MEM_UNITS  = 4;   // byte lanes per word
    localparam int SHAMT_W    = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [XLEN-1:0]       addr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [MEM_UNITS-1:0]  wem_t;

    // --------------------------------------------------
    // major opcodes, inst[6:0]
    // --------------------------------------------------
    typedef enum logic [6:0] {
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA
    } alu_op_e;

    // encoding follows funct3[1:0] of stores
    typedef enum logic [1:0] {
        SZ_BYTE = 2'b00,
        SZ_HALF = 2'b01,
        SZ_WORD = 2'b10,
        SZ_NONE = 2'b11
    } store_size_e;

    // --------------------------------------------------
    // funct fields
    // --------------------------------------------------
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;  // sub / sra

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_SB   = 3'b000;
    localparam logic [2:0] F3_SH   = 3'b001;
    localparam logic [2:0] F3_SW   = 3'b010;

    localparam addr_t JUMP_NONE_BASE = 32'h0000_0000;  // reset address

endpackage

/* rtl/ex_stage_reg.sv */
// one-entry stage register; upstream must keep its input stable while hold_i is high
`timescale 1ns/1ps
module ex_stage_reg import ex_pkg::*; (
    input  logic  clk,
    input  logic  rstn,
    input  logic  hold_i,
    input  logic  flush_i,
    ex_bus_if.dst exec_bus,
    ex_bus_if.src held_bus
);

    logic        valid_q;
    logic        wen_q;
    reg_addr_t   rd_q;
    word_t       result_q;
    logic        mem_access_q;
    logic        mem_write_q;
    addr_t       mem_addr_q;
    word_t       store_data_q;
    store_size_e store_size_q;
    logic        jump_en_q;
    addr_t       jump_base_q;
    addr_t       jump_ofst_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q      <= 1'b0;
            wen_q        <= 1'b0;
            rd_q         <= '0;
            result_q     <= '0;
            mem_access_q <= 1'b0;
            mem_write_q  <= 1'b0;
            mem_addr_q   <= '0;
            store_data_q <= '0;
            store_size_q <= SZ_NONE;
            jump_en_q    <= 1'b0;
            jump_base_q  <= JUMP_NONE_BASE;
            jump_ofst_q  <= '0;
        end else begin
            // flush wins over hold
            if (flush_i) begin
                valid_q <= 1'b0;
            end else if (!hold_i) begin
                valid_q <= exec_bus.valid;
            end
            if (!hold_i) begin
                wen_q        <= exec_bus.wen;
                rd_q         <= exec_bus.rd;
                result_q     <= exec_bus.result;
                mem_access_q <= exec_bus.mem_access;
                mem_write_q  <= exec_bus.mem_write;
                mem_addr_q   <= exec_bus.mem_addr;
                store_data_q <= exec_bus.store_data;
                store_size_q <= exec_bus.store_size;
                jump_en_q    <= exec_bus.jump_en;
                jump_base_q  <= exec_bus.jump_base;
                jump_ofst_q  <= exec_bus.jump_ofst;
            end
        end
    end

    // entry stays hidden while held, shown once hold drops
    assign held_bus.valid      = valid_q & ~hold_i;
    assign held_bus.wen        = wen_q;
    assign held_bus.rd         = rd_q;
    assign held_bus.result     = result_q;
    assign held_bus.mem_access = mem_access_q;
    assign held_bus.mem_write  = mem_write_q;
    assign held_bus.mem_addr   = mem_addr_q;
    assign held_bus.store_data = store_data_q;
    assign held_bus.store_size = store_size_q;
    assign held_bus.jump_en    = jump_en_q;
    assign held_bus.jump_base  = jump_base_q;
    assign held_bus.jump_ofst  = jump_ofst_q;

endmodule

/* rtl/ex_top.sv */
// two-cycle RV32I execute stage; each hold_i cycle adds one cycle, flush_i drops the held entry
`timescale 1ns/1ps
module ex_top import ex_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      hold_i,
    input  logic      flush_i,
    // from decode
    input  logic      valid_i,
    input  word_t     inst_i,
    input  addr_t     instaddr_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    input  word_t     op1_i,
    input  word_t     op2_i,
    input  logic      regs_wen_i,
    input  reg_addr_t rd_addr_i,
    // to writeback, fetch and data memory
    output logic      valid_o,
    output logic      regs_wen_o,
    output reg_addr_t rd_addr_o,
    output word_t     rd_data_o,
    output logic      jump_en_o,
    output addr_t     jump_addr_o,
    output logic      mem_cs_o,
    output logic      mem_we_o,
    output wem_t      mem_wem_o,
    output word_t     mem_din_o,
    output addr_t     mem_addr_o
);

    ex_bus_if exec_bus ();   // combinational result
    ex_bus_if held_bus ();   // after stage register

    ex_alu_branch u_alu_branch (
        .valid_i    (valid_i),
        .inst_i     (inst_i),
        .instaddr_i (instaddr_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .op1_i      (op1_i),
        .op2_i      (op2_i),
        .regs_wen_i (regs_wen_i),
        .rd_addr_i  (rd_addr_i),
        .exec_bus   (exec_bus.src)
    );

    ex_stage_reg u_stage_reg (
        .clk      (clk),
        .rstn     (rstn),
        .hold_i   (hold_i),
        .flush_i  (flush_i),
        .exec_bus (exec_bus.dst),
        .held_bus (held_bus.src)
    );

    ex_mem_format u_mem_format (
        .clk         (clk),
        .rstn        (rstn),
        .held_bus    (held_bus.dst),
        .valid_o     (valid_o),
        .regs_wen_o  (regs_wen_o),
        .rd_addr_o   (rd_addr_o),
        .rd_data_o   (rd_data_o),
        .jump_en_o   (jump_en_o),
        .jump_addr_o (jump_addr_o),
        .mem_cs_o    (mem_cs_o),
        .mem_we_o    (mem_we_o),
        .mem_wem_o   (mem_wem_o),
        .mem_din_o   (mem_din_o),
        .mem_addr_o  (mem_addr_o)
    );

endmodule

/* run.sh */
#!/bin/sh
# builds the ex_top testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ex_top -f project.f -o sim_ex_top

# the run passes only when the pass line shows up in the output
./obj_dir/sim_ex_top | tee /dev/stderr | grep "All checks passed" > /dev/null

/* testbench/ex_top_assert.sv */
// output checks for ex_top; bound inside ex_top, so the port names follow its signals
`timescale 1ns/1ps
module ex_top_assert import ex_pkg::*; (
    input logic clk,
    input logic rstn,
    input logic in_valid_i,
    input logic out_valid_i,
    input logic mem_cs_i,
    input logic mem_we_i,
    input wem_t mem_wem_i
);

    logic seen_q;           // any instruction sampled since reset
    bit   quiet_err = 1'b0;
    bit   cs_err    = 1'b0;
    bit   wem_err   = 1'b0;
    logic failed;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            seen_q <= 1'b0;
        end else if (in_valid_i) begin
            seen_q <= 1'b1;
        end
    end

    assign failed = quiet_err | cs_err | wem_err;

    // --------------------------------------------------
    // properties
    // --------------------------------------------------
    quiet_after_reset: assert property (@(posedge clk) disable iff (!rstn)
        !seen_q |-> !out_valid_i)
    else begin
        $error("valid_o high before any instruction was issued");
        quiet_err = 1'b1;
    end

    write_needs_select: assert property (@(posedge clk) disable iff (!rstn)
        mem_we_i |-> mem_cs_i)
    else begin
        $error("mem_we_o high without mem_cs_o");
        cs_err = 1'b1;
    end

    mask_needs_write: assert property (@(posedge clk) disable iff (!rstn)
        (mem_wem_i != '0) |-> mem_we_i)
    else begin
        $error("mem_wem_o nonzero without mem_we_o");
        wem_err = 1'b1;
    end

endmodule

/* testbench/tb_clkgen.sv */
// free-running 100 ns clock; reset held low for the first 16 rising edges, then released
`timescale 1ns/1ps
module tb_clkgen (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;   // 100 ns period
    end

    initial begin
        rstn_o = 1'b0;
        repeat (16) @(posedge clk_o);
        rstn_o <= 1'b1;
    end

endmodule

/* testbench/tb_ex_top.sv */
// directed tests for ex_top; operands from a fixed seed, results expected two edges after issue
`timescale 1ns/1ps
module tb_ex_top import ex_pkg::*; ();

    logic      clk;
    logic      rstn;
    logic      hold_i;
    logic      flush_i;
    logic      valid_i;
    word_t     inst_i;
    addr_t     instaddr_i;
    word_t     rs1_data_i;
    word_t     rs2_data_i;
    word_t     op1_i;
    word_t     op2_i;
    logic      regs_wen_i;
    reg_addr_t rd_addr_i;
    logic      valid_o;
    logic      regs_wen_o;
    reg_addr_t rd_addr_o;
    word_t     rd_data_o;
    logic      jump_en_o;
    addr_t     jump_addr_o;
    logic      mem_cs_o;
    logic      mem_we_o;
    wem_t      mem_wem_o;
    word_t     mem_din_o;
    addr_t     mem_addr_o;

    int unsigned test_count = 56;   // instructions issued over all tests

    tb_clkgen u_clkgen (.clk_o(clk), .rstn_o(rstn));

    ex_top DUT (.*);

    bind ex_top ex_top_assert u_top_assert (
        .clk         (clk),
        .rstn        (rstn),
        .in_valid_i  (valid_i),
        .out_valid_i (valid_o),
        .mem_cs_i    (mem_cs_o),
        .mem_we_i    (mem_we_o),
        .mem_wem_i   (mem_wem_o)
    );

    // --------------------------------------------------
    // error handling and compare tasks
    // --------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            abort_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp)
            abort_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_wem(input string name, input wem_t exp, input wem_t act);
        if (act !== exp)
            abort_run($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp)
            abort_run($sformatf("Mismatch in %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
    endtask

    // --------------------------------------------------
    // reference model and instruction encoders
    // --------------------------------------------------
    function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
        word_t res;
        case (op)
            ADD:     res = a + b;
            SUB:     res = a - b;
            AND:     res = a & b;
            OR:      res = a | b;
            XOR:     res = a ^ b;
            SLT:     res = word_t'($signed(a) < $signed(b));
            SLTU:    res = word_t'(a < b);
            SLL:     res = a << b[4:0];
            SRL:     res = a >> b[4:0];
            default: res = word_t'($signed(a) >>> b[4:0]);   // SRA
        endcase
        return res;
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // per lane: byte store fills lane ofs, half fills its half, word fills all
    function automatic void lane_model(input logic [2:0] f3, input logic [1:0] ofs,
                                       input word_t d, output word_t din, output wem_t wem);
        din = '0;
        wem = '0;
        for (int l = 0; l < 4; l++) begin
            if (f3 == 3'b010 || (f3 == 3'b001 && l[1] == ofs[1]) ||
                (f3 == 3'b000 && l[1:0] == ofs)) begin
                wem[l] = 1'b1;
                din[8*l +: 8] = (f3 == 3'b000) ? d[7:0] :
                                (f3 == 3'b001) ? d[8*l[0] +: 8] : d[8*l +: 8];
            end
        end
    endfunction

    function automatic word_t r_type(input alu_op_e op);
        logic [6:0] f7;
        logic [2:0] f3;
        f7 = 7'b0000000;
        case (op)
            ADD:     f3 = 3'b000;
            SUB: begin
                f3 = 3'b000;
                f7 = 7'b0100000;
            end
            SLL:     f3 = 3'b001;
            SLT:     f3 = 3'b010;
            SLTU:    f3 = 3'b011;
            XOR:     f3 = 3'b100;
            SRL:     f3 = 3'b101;
            SRA: begin
                f3 = 3'b101;
                f7 = 7'b0100000;
            end
            OR:      f3 = 3'b110;
            default: f3 = 3'b111;
        endcase
        return {f7, 5'd2, 5'd1, f3, 5'd3, OP_REG};   // rd x3, rs1 x1, rs2 x2
    endfunction

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    task automatic drive(input word_t inst, input addr_t pc, input word_t rs1, input word_t rs2,
                         input word_t op1, input word_t op2, input logic wen);
        @(posedge clk);
        valid_i    <= 1'b1;
        inst_i     <= inst;
        instaddr_i <= pc;
        rs1_data_i <= rs1;
        rs2_data_i <= rs2;
        op1_i      <= op1;
        op2_i      <= op2;
        regs_wen_i <= wen;
        rd_addr_i  <= inst[11:7];
    endtask

    // one instruction for one cycle, outputs read two edges later
    task automatic issue(input string name, input word_t inst, input addr_t pc,
                         input word_t rs1, input word_t rs2, input word_t op1, input word_t op2,
                         input logic wen);
        drive(inst, pc, rs1, rs2, op1, op2, wen);
        @(posedge clk);
        valid_i <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        if (valid_o !== 1'b1)
            abort_run($sformatf("%s: valid_o did not rise two cycles after issue", name));
        check_reg({name, " rd_addr"}, inst[11:7], rd_addr_o);
    endtask

    task automatic alu_tests();
        alu_op_e ops [10] = '{ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA};
        word_t   a;
        word_t   b;
        string   name;
        for (int i = 0; i < 10; i++) begin
            for (int r = 0; r < 3; r++) begin
                a = $urandom();
                b = $urandom();
                if (r == 0)
                    a[31] = 1'b1;   // negative op1 for sra and slt
                name = $sformatf("alu %s", ops[i].name());
                issue(name, r_type(ops[i]), 32'h0, a, b, a, b, 1'b1);
                check_word(name, alu_model(ops[i], a, b), rd_data_o);
                check_bit({name, " regs_wen"}, 1'b1, regs_wen_o);
            end
        end
    endtask

    task automatic branch_tests();
        logic [2:0] f3s [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        string      names [6] = '{"beq", "bne", "blt", "bge", "bltu", "bgeu"};
        word_t      a;
        word_t      b;
        word_t      off;
        addr_t      pc;
        logic       taken;
        for (int i = 0; i < 6; i++) begin
            for (int r = 0; r < 2; r++) begin
                a   = $urandom();
                b   = (r == 0) ? word_t'($urandom()) : a;   // equal operands second
                off = $urandom();
                off = {{19{off[12]}}, off[12:1], 1'b0};
                pc  = $urandom() & 32'hffff_fffc;
                taken = branch_model(f3s[i], a, b);
                issue(names[i], {off[12], off[10:5], 5'd2, 5'd1, f3s[i], off[4:1], off[11],
                      OP_BRANCH}, pc, a, b, a, b, 1'b1);
                check_bit({names[i], " jump_en"}, taken, jump_en_o);
                check_addr({names[i], " jump_addr"}, taken ? pc + off : JUMP_NONE_BASE,
                           jump_addr_o);
                check_bit({names[i], " regs_wen"}, 1'b0, regs_wen_o);
            end
        end
    endtask

    task automatic jump_tests();
        word_t off;
        word_t rs1;
        addr_t pc;
        off = $urandom();
        off = {{11{off[20]}}, off[20:1], 1'b0};
        pc  = $urandom() & 32'hffff_fffc;
        issue("jal", {off[20], off[10:1], off[11], off[19:12], 5'd1, OP_JAL},
              pc, 32'h0, 32'h0, pc, 32'd4, 1'b1);
        check_word("jal link", pc + 32'd4, rd_data_o);
        check_bit("jal jump_en", 1'b1, jump_en_o);
        check_addr("jal target", pc + off, jump_addr_o);
        off = $urandom();
        off = {{20{off[11]}}, off[11:0]};
        rs1 = $urandom();
        pc  = $urandom() & 32'hffff_fffc;
        issue("jalr", {off[11:0], 5'd1, 3'b000, 5'd1, OP_JALR},
              pc, rs1, 32'h0, pc, 32'd4, 1'b1);
        check_word("jalr link", pc + 32'd4, rd_data_o);
        check_bit("jalr jump_en", 1'b1, jump_en_o);
        check_addr("jalr target", rs1 + off, jump_addr_o);
    endtask

    task automatic store_case(input string name, input logic [2:0] f3, input logic [1:0] ofs);
        word_t base;
        word_t data;
        word_t din;
        wem_t  wem;
        base = $urandom() & 32'hffff_fffc;
        data = $urandom();
        lane_model(f3, ofs, data, din, wem);
        issue(name, {7'b0, 5'd2, 5'd1, f3, 5'b0, OP_STORE}, 32'h0, base, data,
              base, {30'b0, ofs}, 1'b1);
        check_bit({name, " mem_cs"}, 1'b1, mem_cs_o);
        check_bit({name, " mem_we"}, 1'b1, mem_we_o);
        check_wem({name, " mask"}, wem, mem_wem_o);
        check_word({name, " data"}, din, mem_din_o);
        check_addr({name, " addr"}, base + {30'b0, ofs}, mem_addr_o);
        check_bit({name, " regs_wen"}, 1'b0, regs_wen_o);
    endtask

    task automatic memory_tests();
        word_t base;
        word_t ofs;
        for (int k = 0; k < 4; k++)
            store_case($sformatf("sb offset %0d", k), 3'b000, k[1:0]);
        store_case("sh low", 3'b001, 2'd0);
        store_case("sh high", 3'b001, 2'd2);
        store_case("sw", 3'b010, 2'd0);
        base = $urandom();
        ofs  = $urandom();
        issue("lw", {12'h0, 5'd1, 3'b010, 5'd5, OP_LOAD}, 32'h0, base, 32'h0, base, ofs, 1'b1);
        check_bit("lw mem_cs", 1'b1, mem_cs_o);
        check_bit("lw mem_we", 1'b0, mem_we_o);
        check_wem("lw mask", 4'b0000, mem_wem_o);
        check_addr("lw addr", base + ofs, mem_addr_o);
        check_bit("lw regs_wen", 1'b1, regs_wen_o);
    endtask

    // hold for three cycles after capture, optionally flushing the held entry
    task automatic hold_flush_test(input string name, input logic do_flush);
        word_t a;
        word_t b;
        int    seen;
        int    at;
        int    exp_seen;
        a = $urandom();
        b = $urandom();
        seen = 0;
        at = 0;
        exp_seen = do_flush ? 0 : 1;
        drive(r_type(ADD), 32'h0, a, b, a, b, 1'b1);
        for (int c = 1; c <= 8; c++) begin
            @(posedge clk);
            if (c == 1) begin
                valid_i <= 1'b0;
                hold_i  <= 1'b1;
            end
            if (c == 2 && do_flush)
                flush_i <= 1'b1;
            if (c == 3)
                flush_i <= 1'b0;
            if (c == 4)
                hold_i <= 1'b0;   // three held edges
            @(negedge clk);
            if (valid_o === 1'b1) begin
                seen++;
                at = c;
                check_word({name, " rd_data"}, a + b, rd_data_o);
            end
        end
        if (seen != exp_seen || (!do_flush && at != 5))
            abort_run($sformatf("Mismatch in %s: expected valid_o %0d time(s) at cycle 5, %s",
                                name, exp_seen,
                                $sformatf("actual %0d time(s), last at %0d", seen, at)));
    endtask

    task automatic upper_tests();
        word_t imm;
        addr_t pc;
        imm = $urandom() & 32'hffff_f000;
        issue("lui", {imm[31:12], 5'd4, OP_LUI}, 32'h0, 32'h0, 32'h0, 32'h0, imm, 1'b1);
        check_word("lui", imm, rd_data_o);
        imm = $urandom() & 32'hffff_f000;
        pc  = $urandom() & 32'hffff_fffc;
        issue("auipc", {imm[31:12], 5'd4, OP_AUIPC}, pc, 32'h0, 32'h0, pc, imm, 1'b1);
        check_word("auipc", pc + imm, rd_data_o);
    endtask

    // --------------------------------------------------
    // main sequence and watchdog
    // --------------------------------------------------
    initial begin
        void'($urandom(32'hc509_6201));
        hold_i     = 1'b0;
        flush_i    = 1'b0;
        valid_i    = 1'b0;
        inst_i     = '0;
        instaddr_i = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        op1_i      = '0;
        op2_i      = '0;
        regs_wen_i = 1'b0;
        rd_addr_i  = '0;
        wait (rstn === 1'b1);
        alu_tests();
        branch_tests();
        jump_tests();
        memory_tests();
        hold_flush_test("hold", 1'b0);
        hold_flush_test("flush", 1'b1);
        upper_tests();
        if (DUT.u_top_assert.failed !== 1'b1) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (test_count * 10 + 16) @(posedge clk);
        abort_run("watchdog expired before the tests finished");
    end

endmodule
